//--- compile.f
source/alpha_pkg.sv
source/lane_sync.sv
source/alpha_readout.sv
source/word_collector.sv
source/bias_loader.sv
source/alpha_readout_top.sv
sim/tb_alpha_readout_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_alpha_readout_top
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG := SOME TESTS FAILED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail if the log reports failure"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_alpha_readout_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_alpha_readout_top import alpha_pkg::*; ();

	localparam int NOISE_ROUNDS = 3;
	localparam int NUM_WORDS = 1 + NUM_LANES + NOISE_ROUNDS * NUM_LANES;
	localparam int NUM_LOADS = 2;
	localparam int LIMIT_CYCLES = 40 * NUM_WORDS + 120 * NUM_LOADS + 200;
	localparam int FRAME_BITS = HEADER_BITS + 16;

	logic sysclk;
	logic reset;
	logic [NUM_LANES-1:0] data_lanes;
	logic bias_load;
	bias_set_t bias_settings;
	word_t word_out;
	logic word_valid;
	logic sin;
	logic sclk;
	logic pclk;
	logic bias_busy;

	logic [31:0] lfsr;
	data_word_t expected_q[NUM_LANES][$];
	// mirror of each lane's header shift register while it hunts
	logic [HEADER_BITS-1:0] idle_win[NUM_LANES];
	bias_set_t bias_expected;
	logic [BIAS_BITS-1:0] shifted;
	int sclk_rises;
	int pclk_count;
	logic sclk_prev;

	alpha_readout_top i_dut (
		.sysclk(sysclk),
		.reset(reset),
		.data_lanes(data_lanes),
		.bias_load(bias_load),
		.bias_settings(bias_settings),
		.word_out(word_out),
		.word_valid(word_valid),
		.sin(sin),
		.sclk(sclk),
		.pclk(pclk),
		.bias_busy(bias_busy)
	);

	initial begin
		sysclk = 1'b0;
		forever #50 sysclk = ~sysclk;
	end

	// --------------------------------------------------------------------------
	// helpers and reference functions
	// --------------------------------------------------------------------------
	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	function automatic string error_line(input string msg);
		return $sformatf("** Error at %0d ns: %s", $time, msg);
	endfunction

	// galois form, taps 32 30 26 25
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'hA3000000;
		end
		return s >> 1;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return r;
	endfunction

	// header then data, both msb first
	function automatic logic [FRAME_BITS-1:0] make_frame(input data_word_t data);
		return {ALPHA_HEADER, data[15:12], data[11:8], data[7:4], data[3:0]};
	endfunction

	function automatic logic expected_sin(input bias_set_t set, input int rise);
		logic [BIAS_BITS-1:0] bits;
		bits = set;
		return bits[BIAS_BITS-1-rise];
	endfunction

	// idle bit that can never complete a header
	function automatic logic idle_bit(input int lane, input logic noisy);
		logic [31:0] r;
		logic b;
		r = noisy ? random_bits(1) : 32'd0;
		b = r[0];
		if ({idle_win[lane][HEADER_BITS-2:0], b} == ALPHA_HEADER) begin
			b = ~b;
		end
		idle_win[lane] = {idle_win[lane][HEADER_BITS-2:0], b};
		return b;
	endfunction

	function automatic int queues_pending();
		int n;
		n = 0;
		for (int l = 0; l < NUM_LANES; l++) begin
			n += expected_q[l].size();
		end
		return n;
	endfunction

	task automatic next_cycle();
		@(posedge sysclk);
		#10;
	endtask

	// --------------------------------------------------------------------------
	// stimulus
	// --------------------------------------------------------------------------
	task automatic send_words(input logic [NUM_LANES-1:0] mask, input int idle_cycles,
			input logic noisy, input logic hide_header);
		logic [FRAME_BITS-1:0] frame[NUM_LANES];
		data_word_t data;
		for (int c = 0; c < idle_cycles; c++) begin
			next_cycle();
			for (int l = 0; l < NUM_LANES; l++) begin
				data_lanes[l] = idle_bit(l, noisy);
			end
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			data = data_word_t'(random_bits(16));
			if (hide_header) begin
				data[11:4] = ALPHA_HEADER;
			end
			frame[l] = make_frame(data);
			if (mask[l]) begin
				expected_q[l].push_back(data);
			end
		end
		for (int b = FRAME_BITS - 1; b >= 0; b--) begin
			next_cycle();
			for (int l = 0; l < NUM_LANES; l++) begin
				data_lanes[l] = mask[l] ? frame[l][b] : idle_bit(l, noisy);
			end
		end
		// lane is back in hunt with a cleared shift register
		for (int l = 0; l < NUM_LANES; l++) begin
			if (mask[l]) begin
				idle_win[l] = '0;
			end
		end
		for (int c = 0; c < 8; c++) begin
			next_cycle();
			for (int l = 0; l < NUM_LANES; l++) begin
				data_lanes[l] = idle_bit(l, 1'b0);
			end
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (queues_pending() != 0 && n < 40) begin
			next_cycle();
			n++;
		end
	endtask

	task automatic load_bias(input logic second_load);
		logic [31:0] hi;
		logic [31:0] lo;
		int start_count;
		int n;
		start_count = pclk_count;
		hi = random_bits(16);
		lo = random_bits(32);
		next_cycle();
		bias_settings = {hi[15:0], lo};
		bias_expected = {hi[15:0], lo};
		bias_load = 1'b1;
		next_cycle();
		bias_load = 1'b0;
		if (second_load) begin
			repeat (20) next_cycle();
			bias_settings = ~bias_expected;
			bias_load = 1'b1;
			next_cycle();
			bias_load = 1'b0;
		end
		n = 0;
		while (pclk_count == start_count && n < 120) begin
			next_cycle();
			n++;
		end
		assert (pclk_count != start_count) else stop_run("no pclk pulse came after a bias load");
		assert (!bias_busy) else stop_run(error_line("bias_busy still high after pclk"));
		repeat (10) next_cycle();
		assert (pclk_count == start_count + 1) else
			stop_run(error_line($sformatf("%0d pclk pulses for one load", pclk_count - start_count)));
	endtask

	// --------------------------------------------------------------------------
	// comparison processes
	// --------------------------------------------------------------------------
	always @(negedge sysclk) begin
		if (!reset && word_valid) begin
			assert (expected_q[word_out.lane].size() > 0) else
				stop_run(error_line($sformatf("unexpected word %h on lane %0d",
					word_out.data, word_out.lane)));
			assert (word_out.data == expected_q[word_out.lane][0]) else
				stop_run(error_line($sformatf("lane %0d word %h, expected %h", word_out.lane,
					word_out.data, expected_q[word_out.lane][0])));
			void'(expected_q[word_out.lane].pop_front());
		end
	end

	always @(negedge sysclk) begin
		if (reset) begin
			sclk_prev = 1'b0;
			sclk_rises = 0;
			pclk_count = 0;
		end else begin
			if (sclk && !sclk_prev) begin
				assert (bias_busy) else
					stop_run(error_line("bias_busy low during a shift"));
				assert (sclk_rises < BIAS_BITS && sin == expected_sin(bias_expected, sclk_rises))
					else stop_run(error_line($sformatf("sin wrong at sclk rise %0d", sclk_rises)));
				shifted = {shifted[BIAS_BITS-2:0], sin};
				sclk_rises++;
			end
			if (pclk) begin
				assert (sclk_rises == BIAS_BITS && shifted == bias_expected) else
					stop_run(error_line($sformatf("shifted %h after %0d rises, expected %h",
						shifted, sclk_rises, bias_expected)));
				pclk_count++;
				sclk_rises = 0;
			end
			sclk_prev = sclk;
		end
	end

	initial begin
		#(LIMIT_CYCLES * 100);
		stop_run("timeout, the test did not finish in the expected run time");
	end

	// --------------------------------------------------------------------------
	// test sequence
	// --------------------------------------------------------------------------
	initial begin
		lfsr = 32'h8a841693;
		reset = 1'b1;
		data_lanes = '0;
		bias_load = 1'b0;
		bias_settings = '0;
		bias_expected = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			idle_win[l] = '0;
		end
		repeat (2) next_cycle();
		reset = 1'b0;
		repeat (4) begin
			next_cycle();
			assert ({word_valid, sclk, pclk, sin, bias_busy} == 5'b0) else
				stop_run(error_line("outputs not low after reset"));
		end
		send_words(4'b0001, 4, 1'b0, 1'b0);
		wait_drained();
		send_words(4'b1111, 4, 1'b0, 1'b0);
		wait_drained();
		for (int r = 0; r < NOISE_ROUNDS; r++) begin
			send_words(4'b1111, 20, 1'b1, r == 0);
			wait_drained();
		end
		load_bias(1'b0);
		load_bias(1'b1);
		if (queues_pending() == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			stop_run($sformatf("%0d sent words never came out", queues_pending()));
		end
	end

endmodule

`default_nettype wire

//--- source/alpha_readout_top.sv
`timescale 1ns/100ps
`default_nettype none

module alpha_readout_top import alpha_pkg::*; (
	input logic sysclk,
	input logic reset,
	input logic [NUM_LANES-1:0] data_lanes,
	input logic bias_load,
	input bias_set_t bias_settings,
	output word_t word_out,
	output logic word_valid,
	output logic sin,
	output logic sclk,
	output logic pclk,
	output logic bias_busy
);

	logic [NUM_LANES-1:0] synced_lanes;
	logic [NUM_LANES-1:0] word_done;
	data_word_t [NUM_LANES-1:0] word_data;

	// --------------------------------------------------------------------------
	// readout path
	// --------------------------------------------------------------------------
	lane_sync i_lane_sync (
		.sysclk(sysclk),
		.reset(reset),
		.data_lanes(data_lanes),
		.synced_lanes(synced_lanes)
	);

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		alpha_readout i_alpha_readout (
			.sysclk(sysclk),
			.reset(reset),
			.serial_in(synced_lanes[i]),
			.word_done(word_done[i]),
			.word_data(word_data[i])
		);
	end

	word_collector i_word_collector (
		.sysclk(sysclk),
		.reset(reset),
		.word_done(word_done),
		.word_data(word_data),
		.word_out(word_out),
		.word_valid(word_valid)
	);

	// --------------------------------------------------------------------------
	// bias setup
	// --------------------------------------------------------------------------
	bias_loader i_bias_loader (
		.sysclk(sysclk),
		.reset(reset),
		.bias_load(bias_load),
		.bias_settings(bias_settings),
		.sin(sin),
		.sclk(sclk),
		.pclk(pclk),
		.bias_busy(bias_busy)
	);

endmodule

`default_nettype wire

//--- source/bias_loader.sv
`timescale 1ns/100ps
`default_nettype none

module bias_loader import alpha_pkg::*; (
	input logic sysclk,
	input logic reset,
	input logic bias_load,
	input bias_set_t bias_settings,
	output logic sin,
	output logic sclk,
	output logic pclk,
	output logic bias_busy
);

	logic [BIAS_BITS-1:0] shift_reg;
	logic [$clog2(BIAS_BITS)-1:0] bit_cnt;
	logic phase;
	logic start;
	logic last_bit;

	// loads during a shift are dropped
	assign start = bias_load && !bias_busy;
	assign last_bit = phase && (bit_cnt == BIAS_BITS - 1);
	assign sclk = phase;

	// --------------------------------------------------------------------------
	// shift sequencing, two cycles per bit then one pclk cycle
	// --------------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			bias_busy <= 1'b0;
			phase <= 1'b0;
			pclk <= 1'b0;
			sin <= 1'b0;
			bit_cnt <= '0;
		end else if (start) begin
			bias_busy <= 1'b1;
			phase <= 1'b0;
			bit_cnt <= '0;
			sin <= bias_settings[BIAS_BITS-1];
		end else if (pclk) begin
			pclk <= 1'b0;
			bias_busy <= 1'b0;
		end else if (bias_busy) begin
			phase <= !phase;
			// next bit goes out after sclk high
			if (phase) begin
				bit_cnt <= bit_cnt + 1'b1;
				sin <= last_bit ? 1'b0 : shift_reg[BIAS_BITS-2];
				pclk <= last_bit;
			end
		end
	end

	always_ff @(posedge sysclk) begin
		if (start) begin
			shift_reg <= bias_settings;
		end else if (bias_busy && phase) begin
			shift_reg <= shift_reg << 1;
		end
	end

	// latch comes only after the last clock edge has ended
	assert property (@(posedge sysclk) disable iff (reset) pclk |-> !sclk && $past(sclk));

endmodule

`default_nettype wire

//--- source/word_collector.sv
`timescale 1ns/100ps
`default_nettype none

module word_collector import alpha_pkg::*; (
	input logic sysclk,
	input logic reset,
	input logic [NUM_LANES-1:0] word_done,
	input data_word_t [NUM_LANES-1:0] word_data,
	output word_t word_out,
	output logic word_valid
);

	logic [NUM_LANES-1:0] full;
	data_word_t [NUM_LANES-1:0] slot;
	lane_id_t rr_ptr;
	lane_id_t sel_lane;
	logic sel_found;

	// first full slot at or after the pointer
	always_comb begin
		lane_id_t idx;
		sel_found = 1'b0;
		sel_lane = rr_ptr;
		for (int k = NUM_LANES - 1; k >= 0; k--) begin
			idx = rr_ptr + lane_id_t'(k);
			if (full[idx]) begin
				sel_found = 1'b1;
				sel_lane = idx;
			end
		end
	end

	always_ff @(posedge sysclk) begin
		if (reset) begin
			full <= '0;
			rr_ptr <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= sel_found;
			if (sel_found) begin
				rr_ptr <= sel_lane + 1'b1;
			end
			for (int i = 0; i < NUM_LANES; i++) begin
				if (word_done[i]) begin
					full[i] <= 1'b1;
				end else if (sel_found && sel_lane == lane_id_t'(i)) begin
					full[i] <= 1'b0;
				end
			end
		end
	end

	// slot contents and output word
	always_ff @(posedge sysclk) begin
		for (int i = 0; i < NUM_LANES; i++) begin
			if (word_done[i]) begin
				slot[i] <= word_data[i];
			end
		end
		word_out.lane <= sel_lane;
		word_out.data <= slot[sel_lane];
	end

	// word gap on a lane is longer than one full scan
	assert property (@(posedge sysclk) disable iff (reset) (word_done & full) == '0);

endmodule

`default_nettype wire

//--- source/alpha_readout.sv
`timescale 1ns/100ps
`default_nettype none

module alpha_readout import alpha_pkg::*; (
	input logic sysclk,
	input logic reset,
	input logic serial_in,
	output logic word_done,
	output data_word_t word_data
);

	readout_state_t state;
	logic [HEADER_BITS-1:0] header_sr;
	logic [HEADER_BITS-1:0] header_next;
	logic [1:0] bit_cnt;
	logic [1:0] nybble_cnt;
	nybble_t nybble;
	nybble_t nybble_next;
	logic msn;
	logic last_bit;

	assign header_next = {header_sr[HEADER_BITS-2:0], serial_in};
	assign nybble_next = {nybble[2:0], serial_in};
	// most significant nybble of the word
	assign msn = (nybble_cnt == 2'd0);
	assign last_bit = (state == collect) && (bit_cnt == 2'd3) && (nybble_cnt == 2'd3);

	// --------------------------------------------------------------------------
	// header search and collect sequencing
	// --------------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (reset) begin
			state <= hunt;
			header_sr <= '0;
			bit_cnt <= '0;
			nybble_cnt <= '0;
			word_done <= 1'b0;
		end else begin
			word_done <= last_bit;
			case (state)
				hunt: begin
					if (header_next == ALPHA_HEADER) begin
						state <= collect;
						header_sr <= '0;
						bit_cnt <= '0;
						nybble_cnt <= '0;
					end else begin
						header_sr <= header_next;
					end
				end
				collect: begin
					bit_cnt <= bit_cnt + 2'd1;
					if (bit_cnt == 2'd3) begin
						nybble_cnt <= nybble_cnt + 2'd1;
					end
					// cleared header_sr keeps data bits from faking a header
					if (last_bit) begin
						state <= hunt;
					end
				end
				default: state <= hunt;
			endcase
		end
	end

	// --------------------------------------------------------------------------
	// nybble assembly, msn first
	// --------------------------------------------------------------------------
	always_ff @(posedge sysclk) begin
		if (state == collect) begin
			nybble <= nybble_next;
			if (bit_cnt == 2'd3) begin
				if (msn) begin
					word_data <= {12'h000, nybble_next};
				end else begin
					word_data <= {word_data[11:0], nybble_next};
				end
			end
		end
	end

	// one strobe per word, lane back in hunt right after it
	assert property (@(posedge sysclk) disable iff (reset)
		(word_done && state == hunt) |=> !word_done);

endmodule

`default_nettype wire

//--- source/lane_sync.sv
`timescale 1ns/100ps
`default_nettype none

module lane_sync import alpha_pkg::*; (
	input logic sysclk,
	input logic reset,
	input logic [NUM_LANES-1:0] data_lanes,
	output logic [NUM_LANES-1:0] synced_lanes
);

	// first stage may go metastable
	logic [NUM_LANES-1:0] meta;

	always_ff @(posedge sysclk) begin
		if (reset) begin
			meta <= '0;
			synced_lanes <= '0;
		end else begin
			meta <= data_lanes;
			synced_lanes <= meta;
		end
	end

endmodule

`default_nettype wire

//--- source/alpha_pkg.sv
`default_nettype none

package alpha_pkg;

	// --------------------------------------------------------------------------
	// readout lanes
	// --------------------------------------------------------------------------
	localparam int NUM_LANES = 4;
	localparam int HEADER_BITS = 8;
	// start of every word, sent msb first
	localparam logic [HEADER_BITS-1:0] ALPHA_HEADER = 8'hAC;

	typedef logic [$clog2(NUM_LANES)-1:0] lane_id_t;
	typedef logic [3:0] nybble_t;
	typedef logic [15:0] data_word_t;

	typedef struct packed {
		lane_id_t lane;
		data_word_t data;
	} word_t;

	typedef enum logic {
		hunt,
		collect
	} readout_state_t;

	// --------------------------------------------------------------------------
	// bias DACs
	// --------------------------------------------------------------------------
	localparam int BIAS_BITS = 48;

	typedef logic [11:0] bias_t;

	// cmpbias goes out first
	typedef struct packed {
		bias_t cmpbias;
		bias_t isel;
		bias_t sbbias;
		bias_t dbbias;
	} bias_set_t;

endpackage

`default_nettype wire
